/* src.f */
+incdir+include
rtl/dispatch_pkg.sv
rtl/inst_queue.sv
rtl/decode.sv
rtl/dispatch.sv
rtl/resource_tracker.sv
rtl/dispatch_top.sv
tests/tb_clock.sv
tests/dispatch_checker.sv
tests/dispatch_sva.sv
tests/dispatch_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dispatch_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/dispatch_tb.sv */
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch_tb
    import dispatch_pkg::*;
();

    localparam int N              = `DISP_N;
    localparam int NUM_INSTS      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 40;
    // free-starved window that backs up the queue
    localparam int STARVE_START   = 600;
    localparam int STARVE_END     = 800;

    logic                    clock;
    logic                    arst_n;
    logic                    in_req;
    logic                    in_ack;
    rv_inst_t                in_inst;
    free_t                   free;
    decoded_packet_t [N-1:0] disp_group;
    count_t                  disp_count;
    int                      rob_used = 0;
    int                      rs_used = 0;
    int                      sq_used = 0;
    int                      bs_used = 0;
    int                      cycle = 0;

    tb_clock #(.PERIOD(4)) tb_clock_i (.clock(clock));

    dispatch_top #(.N(N)) dispatch_top_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .in_inst    (in_inst),
        .free       (free),
        .in_ack     (in_ack),
        .disp_group (disp_group),
        .disp_count (disp_count)
    );

    dispatch_checker #(.N(N)) checker_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_inst    (in_inst),
        .free       (free),
        .disp_group (disp_group),
        .disp_count (disp_count)
    );

    bind dispatch_top dispatch_sva #(.N(N)) dispatch_sva_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .disp_group (disp_group),
        .disp_count (disp_count)
    );

    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        int          kind;
        w    = $urandom;
        kind = $urandom_range(0, 99);
        if (kind < 25) w[6:0] = OPC_OP;
        else if (kind < 40) w[6:0] = OPC_OP_IMM;
        else if (kind < 45) w[6:0] = OPC_LUI;
        else if (kind < 62) w[6:0] = OPC_LOAD;
        else if (kind < 78) w[6:0] = OPC_STORE;
        else if (kind < 88) w[6:0] = OPC_BRANCH;
        else if (kind < 93) w[6:0] = OPC_JAL;
        else if (kind < 96) w[6:0] = OPC_JALR;
        else w[6:0] = 7'b0001111;
        return w;
    endfunction

    function automatic count_t random_free(int used);
        int hi;
        hi = (used < N) ? used : N;
        return count_t'($urandom_range(0, hi));
    endfunction

    // four-phase handover entered and left 1 ns after an edge
    task automatic send_inst(input logic [31:0] w);
        int gap;
        in_req  = 1'b1;
        in_inst = w;
        do begin
            @(posedge clock);
            #1;
        end while (!in_ack);
        in_req = 1'b0;
        do begin
            @(posedge clock);
            #1;
        end while (in_ack);
        gap = $urandom_range(0, 3);
        repeat (gap) begin
            @(posedge clock);
            #1;
        end
    endtask

    // frees never exceed what is currently allocated
    always begin
        logic out_of_reset;
        @(posedge clock);
        out_of_reset = arst_n;
        #1;
        if (out_of_reset) begin
            cycle++;
            rob_used += int'(disp_count);
            rs_used  += int'(disp_count);
            for (int i = 0; i < N; i++) begin
                if (disp_group[i].valid && disp_group[i].wr_mem) sq_used++;
            end
            if (disp_group[0].valid && (disp_group[0].cond_branch ||
                                        disp_group[0].uncond_branch)) begin
                bs_used++;
            end
            if (cycle >= STARVE_START && cycle < STARVE_END) begin
                free = '0;
            end else begin
                free.rob = random_free(rob_used);
                free.rs  = random_free(rs_used);
                free.sq  = random_free(sq_used);
                free.bs  = random_free(bs_used);
                rob_used -= int'(free.rob);
                rs_used  -= int'(free.rs);
                sq_used  -= int'(free.sq);
                bs_used  -= int'(free.bs);
            end
        end
    end

    initial begin
        void'($urandom(32'ha75a));
        arst_n  = 1'b0;
        in_req  = 1'b0;
        in_inst = '0;
        free    = '0;
        repeat (10) @(posedge clock);
        #1 arst_n = 1'b1;
        for (int k = 0; k < NUM_INSTS; k++) begin
            send_inst(random_inst());
        end
        wait (checker_i.dispatched == NUM_INSTS);
        repeat (3) @(posedge clock);
        $display("errors: %0d check, %0d assertion, 0 timeout", checker_i.errors,
                 dispatch_top_i.dispatch_sva_i.fail_count);
        if (checker_i.errors == 0 && dispatch_top_i.dispatch_sva_i.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("timeout: only %0d of %0d instructions dispatched after %0d cycles",
                 checker_i.dispatched, NUM_INSTS, TIMEOUT_CYCLES);
        $display("errors: %0d check, %0d assertion, 1 timeout", checker_i.errors,
                 dispatch_top_i.dispatch_sva_i.fail_count);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* tests/dispatch_sva.sv */
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch_sva
    import dispatch_pkg::*;
#(
    parameter int N = `DISP_N
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    in_req,
    input  logic                    in_ack,
    input  decoded_packet_t [N-1:0] disp_group,
    input  count_t                  disp_count
);

    logic hole;
    int   fail_count = 0;

    // a valid slot sitting above an invalid one
    always_comb begin
        hole = 1'b0;
        for (int i = 1; i < N; i++) begin
            if (disp_group[i].valid && !disp_group[i-1].valid) begin
                hole = 1'b1;
            end
        end
    end

    ack_follows_req: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req))
        else begin
            fail_count++;
            $error("in_ack rose while in_req was low");
        end

    count_in_range: assert property (@(posedge clock) disable iff (!arst_n)
        int'(disp_count) <= N)
        else begin
            fail_count++;
            $error("disp_count %0d above dispatch width", disp_count);
        end

    group_contiguous: assert property (@(posedge clock) disable iff (!arst_n)
        !hole)
        else begin
            fail_count++;
            $error("valid slot after an invalid slot in disp_group");
        end

endmodule

/* tests/dispatch_checker.sv */
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch_checker
    import dispatch_pkg::*;
#(
    parameter int N = `DISP_N
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    in_req,
    input  logic                    in_ack,
    input  rv_inst_t                in_inst,
    input  free_t                   free,
    input  decoded_packet_t [N-1:0] disp_group,
    input  count_t                  disp_count
);

    logic [31:0]             iq [$];
    int                      rob_free;
    int                      rs_free;
    int                      sq_free;
    int                      bs_free;
    int                      rob_tail;
    int                      sq_tail;
    logic                    ack_model;
    decoded_packet_t [N-1:0] exp_group;
    int                      exp_count;
    int                      errors = 0;
    int                      dispatched = 0;

    function automatic int min2(int a, int b);
        return (a < b) ? a : b;
    endfunction

    // fields and immediates straight from the RISC-V encoding
    function automatic decoded_packet_t model_decode(logic [31:0] w);
        decoded_packet_t p;
        p = '0;
        p.valid = 1'b1;
        p.inst  = w;
        case (w[6:0])
            OPC_OP: begin
                p.rd  = w[11:7];
                p.rs1 = w[19:15];
                p.rs2 = w[24:20];
            end
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
                p.rd            = w[11:7];
                p.rs1           = w[19:15];
                p.imm           = {{20{w[31]}}, w[31:20]};
                p.rd_mem        = (w[6:0] == OPC_LOAD);
                p.uncond_branch = (w[6:0] == OPC_JALR);
            end
            OPC_STORE: begin
                p.rs1    = w[19:15];
                p.rs2    = w[24:20];
                p.imm    = {{20{w[31]}}, w[31:25], w[11:7]};
                p.wr_mem = 1'b1;
            end
            OPC_BRANCH: begin
                p.rs1         = w[19:15];
                p.rs2         = w[24:20];
                p.imm         = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                p.cond_branch = 1'b1;
            end
            OPC_JAL: begin
                p.rd            = w[11:7];
                p.imm           = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                p.uncond_branch = 1'b1;
            end
            OPC_LUI: begin
                p.rd  = w[11:7];
                p.imm = {w[31:12], 12'b0};
            end
            default: p.illegal = 1'b1;
        endcase
        return p;
    endfunction

    task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    always @(posedge clock or negedge arst_n) begin
        int              n_valid;
        int              limit;
        int              sq_open;
        int              stores;
        int              n;
        logic            stop;
        logic            is_br;
        logic            bs_take;
        logic            push;
        decoded_packet_t p;
        if (!arst_n) begin
            iq.delete();
            rob_free  = `ROB_SZ;
            rs_free   = `RS_SZ;
            sq_free   = `SQ_SZ;
            bs_free   = `BS_SZ;
            rob_tail  = 0;
            sq_tail   = 0;
            ack_model = 1'b0;
            exp_group = '0;
            exp_count = 0;
        end else begin
            // group predicted at the previous edge is registered by now
            compare("disp_count", exp_count, disp_count);
            for (int i = 0; i < N; i++) begin
                compare($sformatf("disp_group slot %0d", i), exp_group[i], disp_group[i]);
            end
            compare("in_ack", ack_model, in_ack);
            push = in_req && !ack_model && (iq.size() < `IQ_DEPTH);

            n_valid = min2(iq.size(), N);
            limit   = min2(n_valid, min2(min2(rob_free, N), min2(rs_free, N)));
            sq_open = min2(sq_free, N);
            stop    = 1'b0;
            bs_take = 1'b0;
            stores  = 0;
            n       = 0;
            exp_group = '0;
            for (int i = 0; i < N; i++) begin
                p = '0;
                if (i < n_valid) begin
                    p = model_decode(iq[i]);
                end
                is_br = p.cond_branch || p.uncond_branch;
                if (i >= limit) stop = 1'b1;
                if (is_br && (i != 0 || bs_free == 0)) stop = 1'b1;
                if (p.wr_mem && stores == sq_open) stop = 1'b1;
                if (!stop) begin
                    if (p.rd_mem || p.wr_mem) begin
                        p.sq_tail = sq_idx_t'((sq_tail + stores) % `SQ_SZ);
                    end
                    p.rob_idx    = rob_idx_t'((rob_tail + i) % `ROB_SZ);
                    exp_group[i] = p;
                    if (p.wr_mem) stores++;
                    if (is_br) bs_take = 1'b1;
                    n++;
                end
            end
            exp_count = n;

            rob_free = rob_free - n + int'(free.rob);
            rs_free  = rs_free - n + int'(free.rs);
            sq_free  = sq_free - stores + int'(free.sq);
            bs_free  = bs_free - int'(bs_take) + int'(free.bs);
            rob_tail = (rob_tail + n) % `ROB_SZ;
            sq_tail  = (sq_tail + stores) % `SQ_SZ;
            for (int i = 0; i < n; i++) begin
                void'(iq.pop_front());
            end
            dispatched += n;

            if (push) begin
                iq.push_back(in_inst);
                ack_model = 1'b1;
            end else if (ack_model && !in_req) begin
                ack_model = 1'b0;
            end
        end
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clock
);

    initial clock = 1'b0;

    always #(PERIOD / 2) clock = ~clock;

endmodule

/* rtl/dispatch_top.sv */
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch_top
    import dispatch_pkg::*;
#(
    parameter int N = `DISP_N
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    in_req,
    input  rv_inst_t                in_inst,
    input  free_t                   free,
    output logic                    in_ack,
    output decoded_packet_t [N-1:0] disp_group,
    output count_t                  disp_count
);

    inst_packet_t    [N-1:0] head_insts;
    decoded_packet_t [N-1:0] id_packet;
    decoded_packet_t [N-1:0] out_insts;
    count_t                  num_dispatch;
    count_t                  num_store_dispatched;
    count_t                  rob_open;
    count_t                  rs_open;
    count_t                  sq_open;
    logic                    bs_full;
    sq_idx_t                 sq_tail;

    inst_queue #(
        .N(N)
    ) inst_queue_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .in_req       (in_req),
        .in_inst      (in_inst),
        .num_dispatch (num_dispatch),
        .in_ack       (in_ack),
        .head_insts   (head_insts)
    );

    decode #(
        .N(N)
    ) decode_i (
        .insts     (head_insts),
        .id_packet (id_packet)
    );

    dispatch #(
        .N(N)
    ) dispatch_i (
        .rob_open             (rob_open),
        .rs_open              (rs_open),
        .sq_open              (sq_open),
        .sq_tail_in           (sq_tail),
        .insts                (id_packet),
        .bs_full              (bs_full),
        .num_dispatch         (num_dispatch),
        .num_store_dispatched (num_store_dispatched),
        .out_insts            (out_insts)
    );

    resource_tracker #(
        .N(N)
    ) resource_tracker_i (
        .clock                (clock),
        .arst_n               (arst_n),
        .out_insts            (out_insts),
        .num_dispatch         (num_dispatch),
        .num_store_dispatched (num_store_dispatched),
        .free                 (free),
        .rob_open             (rob_open),
        .rs_open              (rs_open),
        .sq_open              (sq_open),
        .bs_full              (bs_full),
        .sq_tail              (sq_tail),
        .disp_group           (disp_group),
        .disp_count           (disp_count)
    );

endmodule

/* rtl/resource_tracker.sv */
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module resource_tracker
    import dispatch_pkg::*;
#(
    parameter int N = `DISP_N
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  decoded_packet_t [N-1:0] out_insts,
    input  count_t                  num_dispatch,
    input  count_t                  num_store_dispatched,
    input  free_t                   free,
    output count_t                  rob_open,
    output count_t                  rs_open,
    output count_t                  sq_open,
    output logic                    bs_full,
    output sq_idx_t                 sq_tail,
    output decoded_packet_t [N-1:0] disp_group,
    output count_t                  disp_count
);

    logic [$clog2(`ROB_SZ+1)-1:0] rob_free;
    logic [$clog2(`RS_SZ+1)-1:0]  rs_free;
    logic [$clog2(`SQ_SZ+1)-1:0]  sq_free;
    logic [$clog2(`BS_SZ+1)-1:0]  bs_free;
    rob_idx_t                     rob_tail;
    logic                         bs_alloc;
    decoded_packet_t [N-1:0]      stamped;

    // dispatch never needs more than N of anything
    assign rob_open = (int'(rob_free) > N) ? count_t'(N) : count_t'(rob_free);
    assign rs_open  = (int'(rs_free) > N) ? count_t'(N) : count_t'(rs_free);
    assign sq_open  = (int'(sq_free) > N) ? count_t'(N) : count_t'(sq_free);
    assign bs_full  = (bs_free == '0);

    // only slot 0 can carry a dispatched branch
    assign bs_alloc = out_insts[0].valid &&
                      (out_insts[0].cond_branch || out_insts[0].uncond_branch);

    always_comb begin
        stamped = '0;
        for (int i = 0; i < N; i++) begin
            if (i < int'(num_dispatch)) begin
                stamped[i]         = out_insts[i];
                stamped[i].rob_idx = rob_idx_t'((int'(rob_tail) + i) % `ROB_SZ);
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rob_free   <= ($clog2(`ROB_SZ+1))'(`ROB_SZ);
            rs_free    <= ($clog2(`RS_SZ+1))'(`RS_SZ);
            sq_free    <= ($clog2(`SQ_SZ+1))'(`SQ_SZ);
            bs_free    <= ($clog2(`BS_SZ+1))'(`BS_SZ);
            rob_tail   <= '0;
            sq_tail    <= '0;
            disp_group <= '0;
            disp_count <= '0;
        end else begin
            rob_free   <= rob_free - num_dispatch + free.rob;
            rs_free    <= rs_free - num_dispatch + free.rs;
            sq_free    <= sq_free - num_store_dispatched + free.sq;
            bs_free    <= bs_free - bs_alloc + free.bs;
            rob_tail   <= rob_idx_t'((int'(rob_tail) + int'(num_dispatch)) % `ROB_SZ);
            sq_tail    <= sq_idx_t'((int'(sq_tail) + int'(num_store_dispatched)) % `SQ_SZ);
            disp_group <= stamped;
            disp_count <= num_dispatch;
        end
    end

endmodule

/* rtl/dispatch.sv */
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch
    import dispatch_pkg::*;
#(
    parameter int N = `DISP_N
) (
    input  count_t                  rob_open,
    input  count_t                  rs_open,
    input  count_t                  sq_open,
    input  sq_idx_t                 sq_tail_in,
    input  decoded_packet_t [N-1:0] insts,
    input  logic                    bs_full,
    output count_t                  num_dispatch,
    output count_t                  num_store_dispatched,
    output decoded_packet_t [N-1:0] out_insts
);

    count_t num_valid_inst;
    count_t num_rob_rs;
    count_t limit;

    always_comb begin
        num_valid_inst = '0;
        for (int i = 0; i < N; i++) begin
            if (insts[i].valid) begin
                num_valid_inst = num_valid_inst + 1'b1;
            end
        end
    end

    assign num_rob_rs = (rob_open < rs_open) ? rob_open : rs_open;
    assign limit      = (num_valid_inst < num_rob_rs) ? num_valid_inst : num_rob_rs;

    // walk slots in order, first blocked slot ends the group
    always_comb begin
        logic stop;
        logic is_branch;
        logic is_mem;
        stop                 = 1'b0;
        num_dispatch         = '0;
        num_store_dispatched = '0;
        out_insts            = '0;
        for (int i = 0; i < N; i++) begin
            is_branch = insts[i].cond_branch || insts[i].uncond_branch;
            is_mem    = insts[i].rd_mem || insts[i].wr_mem;
            if (!insts[i].valid || i >= int'(limit)) begin
                stop = 1'b1;
            end
            // branch only leads a group, and needs a stack entry
            if (is_branch && (i != 0 || bs_full)) begin
                stop = 1'b1;
            end
            if (insts[i].wr_mem && num_store_dispatched == sq_open) begin
                stop = 1'b1;
            end
            if (!stop) begin
                out_insts[i] = insts[i];
                if (is_mem) begin
                    // position relative to stores taken so far
                    out_insts[i].sq_tail = sq_idx_t'(
                        (int'(sq_tail_in) + int'(num_store_dispatched)) % `SQ_SZ);
                end
                if (insts[i].wr_mem) begin
                    num_store_dispatched = num_store_dispatched + 1'b1;
                end
                num_dispatch = num_dispatch + 1'b1;
            end
        end
    end

endmodule

/* rtl/decode.sv */
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module decode
    import dispatch_pkg::*;
#(
    parameter int N = `DISP_N
) (
    input  inst_packet_t    [N-1:0] insts,
    output decoded_packet_t [N-1:0] id_packet
);

    always_comb begin
        id_packet = '0;
        for (int i = 0; i < N; i++) begin
            rv_inst_t w;
            w = insts[i].inst;
            id_packet[i].valid = insts[i].valid;
            id_packet[i].inst  = w;
            case (w.r.opcode)
                OPC_OP: begin
                    id_packet[i].rd  = w.r.rd;
                    id_packet[i].rs1 = w.r.rs1;
                    id_packet[i].rs2 = w.r.rs2;
                end
                OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
                    id_packet[i].rd  = w.r.rd;
                    id_packet[i].rs1 = w.r.rs1;
                    // I-type, 12 bits from funct7 and rs2
                    id_packet[i].imm = {{20{w.r.funct7[6]}}, w.r.funct7, w.r.rs2};
                    id_packet[i].rd_mem        = (w.r.opcode == OPC_LOAD);
                    id_packet[i].uncond_branch = (w.r.opcode == OPC_JALR);
                end
                OPC_STORE: begin
                    id_packet[i].rs1    = w.r.rs1;
                    id_packet[i].rs2    = w.r.rs2;
                    // S-type, low bits sit in the rd slot
                    id_packet[i].imm    = {{20{w.r.funct7[6]}}, w.r.funct7, w.r.rd};
                    id_packet[i].wr_mem = 1'b1;
                end
                OPC_BRANCH: begin
                    id_packet[i].rs1 = w.b.rs1;
                    id_packet[i].rs2 = w.b.rs2;
                    id_packet[i].imm = {{20{w.b.imm_hi[6]}}, w.b.imm_lo[0],
                                        w.b.imm_hi[5:0], w.b.imm_lo[4:1], 1'b0};
                    id_packet[i].cond_branch = 1'b1;
                end
                OPC_JAL: begin
                    id_packet[i].rd  = w.r.rd;
                    // imm[19:12] lives in the rs1 and funct3 bits
                    id_packet[i].imm = {{12{w.b.imm_hi[6]}}, w.b.rs1, w.b.funct3,
                                        w.b.rs2[0], w.b.imm_hi[5:0], w.b.rs2[4:1], 1'b0};
                    id_packet[i].uncond_branch = 1'b1;
                end
                OPC_LUI: begin
                    id_packet[i].rd  = w.r.rd;
                    id_packet[i].imm = {w.r.funct7, w.r.rs2, w.r.rs1, w.r.funct3, 12'b0};
                end
                default: begin
                    // unknown opcode still flows through as a plain op
                    id_packet[i].illegal = 1'b1;
                end
            endcase
        end
    end

endmodule

/* rtl/inst_queue.sv */
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module inst_queue
    import dispatch_pkg::*;
#(
    parameter int N = `DISP_N
) (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     in_req,
    input  rv_inst_t                 in_inst,
    input  count_t                   num_dispatch,
    output logic                     in_ack,
    output inst_packet_t [N-1:0]     head_insts
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    rv_inst_t         mem [`IQ_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             req_released;

    assign full = (count == CNT_W'(`IQ_DEPTH));

    // accept a new word only while ack is low
    assign push = in_req && !in_ack && !full;

    // producer has finished its half of the handshake
    assign req_released = in_ack && !in_req;

    // oldest entries, valid in order from slot 0
    always_comb begin
        for (int i = 0; i < N; i++) begin
            head_insts[i].valid = (i < int'(count));
            head_insts[i].inst  = mem[(int'(head) + i) % `IQ_DEPTH];
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            in_ack <= 1'b0;
        end else if (push) begin
            in_ack <= 1'b1;
        end else if (req_released) begin
            in_ack <= 1'b0;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pop by however many dispatch took this cycle
            head  <= PTR_W'((int'(head) + int'(num_dispatch)) % `IQ_DEPTH);
            if (push) begin
                tail <= PTR_W'((int'(tail) + 1) % `IQ_DEPTH);
            end
            count <= count + CNT_W'(push) - CNT_W'(num_dispatch);
        end
    end

    // storage array
    always_ff @(posedge clock) begin
        if (push) begin
            mem[tail] <= in_inst;
        end
    end

endmodule

/* rtl/dispatch_pkg.sv */
`include "dispatch_cfg.svh"

package dispatch_pkg;

    // base opcodes handled by decode
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111
    } opcode_t;

    // register-field view, also used for I, S and U immediates
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_fields_t;

    // scattered immediate view for B and J formats
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } rv_split_t;

    typedef union packed {
        rv_fields_t r;
        rv_split_t  b;
    } rv_inst_t;

    typedef logic [$clog2(`DISP_N+1)-1:0] count_t;
    typedef logic [$clog2(`SQ_SZ)-1:0]    sq_idx_t;
    typedef logic [$clog2(`ROB_SZ)-1:0]   rob_idx_t;

    typedef struct packed {
        logic     valid;
        rv_inst_t inst;
    } inst_packet_t;

    typedef struct packed {
        logic        valid;
        rv_inst_t    inst;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic        rd_mem;
        logic        wr_mem;
        logic        cond_branch;
        logic        uncond_branch;
        logic        illegal;
        sq_idx_t     sq_tail;
        rob_idx_t    rob_idx;
    } decoded_packet_t;

    // entries released by the back end this cycle
    typedef struct packed {
        count_t rob;
        count_t rs;
        count_t sq;
        count_t bs;
    } free_t;

endpackage

/* include/dispatch_cfg.svh */
`ifndef DISPATCH_CFG_SVH
`define DISPATCH_CFG_SVH

// dispatch width, instructions per cycle
`define DISP_N 4

// back-end structure sizes
`define ROB_SZ 16
`define RS_SZ 8
`define SQ_SZ 8
`define BS_SZ 4

// front-end instruction buffer
`define IQ_DEPTH 16

`endif
